// ==== bench/frontEndVectors.svh ====
// Stimulus and expected values for the front-end testbench.
// Columns: test name, instruction served at the accepted fetch, rs, rt and
// interrupt level while it sits in decode, then expected fetchPc, decodePc,
// exceptionLevel and cause just before that fetch is accepted.
// Included inside the testbench module.

task automatic loadVectors();
    // Sequential fetch from the boot address
    addRow("boot", PLAIN, 32'h0, 32'h0, 1'b0, `PC_BOOT, 32'h0, 1'b0, CAUSE_INT);
    addRow("seq 1", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3004, 32'h3000, 1'b0, CAUSE_INT);
    addRow("seq 2", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3008, 32'h3004, 1'b0, CAUSE_INT);
    // Conditional branches land on the slot PC plus the offset times 4
    addRow("beq taken", 32'h10220004, 32'h5, 32'h5, 1'b0, 32'h300c, 32'h3008, 1'b0, CAUSE_INT);
    addRow("beq slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3010, 32'h300c, 1'b0, CAUSE_INT);
    addRow("beq target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3020, 32'h3010, 1'b0, CAUSE_INT);
    addRow("beq untaken", 32'h10220004, 32'h5, 32'h6, 1'b0, 32'h3024, 32'h3020, 1'b0, CAUSE_INT);
    addRow("beq fall slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3028, 32'h3024, 1'b0, CAUSE_INT);
    addRow("bne taken", 32'h14220003, 32'h1, 32'h2, 1'b0, 32'h302c, 32'h3028, 1'b0, CAUSE_INT);
    addRow("bne slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3030, 32'h302c, 1'b0, CAUSE_INT);
    addRow("bne target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h303c, 32'h3030, 1'b0, CAUSE_INT);
    addRow("bne untaken", 32'h14220003, 32'h7, 32'h7, 1'b0, 32'h3040, 32'h303c, 1'b0, CAUSE_INT);
    addRow("bne fall slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3044, 32'h3040, 1'b0, CAUSE_INT);
    // Immediate and register jumps
    addRow("j", 32'h08000c40, 32'h0, 32'h0, 1'b0, 32'h3048, 32'h3044, 1'b0, CAUSE_INT);
    addRow("j slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h304c, 32'h3048, 1'b0, CAUSE_INT);
    addRow("j target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3100, 32'h304c, 1'b0, CAUSE_INT);
    addRow("jal", 32'h0c000c80, 32'h0, 32'h0, 1'b0, 32'h3104, 32'h3100, 1'b0, CAUSE_INT);
    addRow("jal slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3108, 32'h3104, 1'b0, CAUSE_INT);
    addRow("jal target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3200, 32'h3108, 1'b0, CAUSE_INT);
    addRow("jr", 32'h00200008, 32'h3300, 32'h0, 1'b0, 32'h3204, 32'h3200, 1'b0, CAUSE_INT);
    addRow("jr slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3208, 32'h3204, 1'b0, CAUSE_INT);
    addRow("jr target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3300, 32'h3208, 1'b0, CAUSE_INT);
    addRow("jalr", 32'h0020f809, 32'h3400, 32'h0, 1'b0, 32'h3304, 32'h3300, 1'b0, CAUSE_INT);
    addRow("jalr slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3308, 32'h3304, 1'b0, CAUSE_INT);
    addRow("jalr target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3400, 32'h3308, 1'b0, CAUSE_INT);
    // Misaligned fetch and an ERET back to its word address
    addRow("jr misaligned", 32'h00200008, 32'h3502, 32'h0, 1'b0, 32'h3404, 32'h3400, 1'b0,
           CAUSE_INT);
    addRow("jr bad slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3408, 32'h3404, 1'b0, CAUSE_INT);
    addRow("misaligned", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3502, 32'h3408, 1'b0, CAUSE_INT);
    addRow("adel flushed", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3506, 32'h3502, 1'b0, CAUSE_INT);
    addRow("adel handler", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT0, 32'h0, 1'b1, CAUSE_ADEL);
    addRow("adel eret", ERET, 32'h0, 32'h0, 1'b0, KTEXT4, KTEXT0, 1'b1, CAUSE_ADEL);
    addRow("eret flushed", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT8, KTEXT4, 1'b1, CAUSE_ADEL);
    addRow("adel return", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3500, 32'h0, 1'b0, CAUSE_ADEL);
    // Interrupt on a plain instruction
    addRow("irq victim", PLAIN, 32'h0, 32'h0, 1'b1, 32'h3504, 32'h3500, 1'b0, CAUSE_ADEL);
    addRow("irq flushed", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3508, 32'h3504, 1'b0, CAUSE_ADEL);
    addRow("irq handler", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT0, 32'h0, 1'b1, CAUSE_INT);
    addRow("irq eret", ERET, 32'h0, 32'h0, 1'b0, KTEXT4, KTEXT0, 1'b1, CAUSE_INT);
    addRow("irq eret flush", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT8, KTEXT4, 1'b1, CAUSE_INT);
    addRow("irq return", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3504, 32'h0, 1'b0, CAUSE_INT);
    // Interrupt in a delay slot restarts at the branch
    addRow("ds beq", 32'h10220008, 32'h1, 32'h1, 1'b0, 32'h3508, 32'h3504, 1'b0, CAUSE_INT);
    addRow("ds victim", PLAIN, 32'h0, 32'h0, 1'b1, 32'h350c, 32'h3508, 1'b0, CAUSE_INT);
    addRow("ds flushed", PLAIN, 32'h0, 32'h0, 1'b0, 32'h352c, 32'h350c, 1'b0, CAUSE_INT);
    addRow("ds handler", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT0, 32'h0, 1'b1, CAUSE_INT);
    addRow("ds eret", ERET, 32'h0, 32'h0, 1'b0, KTEXT4, KTEXT0, 1'b1, CAUSE_INT);
    addRow("ds eret flush", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT8, KTEXT4, 1'b1, CAUSE_INT);
    addRow("ds return", 32'h10220008, 32'h1, 32'h1, 1'b0, 32'h3508, 32'h0, 1'b0, CAUSE_INT);
    addRow("ds slot again", PLAIN, 32'h0, 32'h0, 1'b0, 32'h350c, 32'h3508, 1'b0, CAUSE_INT);
    addRow("ds target", PLAIN, 32'h0, 32'h0, 1'b0, 32'h352c, 32'h350c, 1'b0, CAUSE_INT);
    // Fetch outside instruction memory that stays in the handler
    addRow("jalr range", 32'h0020f809, 32'h6000, 32'h0, 1'b0, 32'h3530, 32'h352c, 1'b0,
           CAUSE_INT);
    addRow("jalr bad slot", PLAIN, 32'h0, 32'h0, 1'b0, 32'h3534, 32'h3530, 1'b0, CAUSE_INT);
    addRow("out of range", PLAIN, 32'h0, 32'h0, 1'b0, 32'h6000, 32'h3534, 1'b0, CAUSE_INT);
    addRow("range flushed", PLAIN, 32'h0, 32'h0, 1'b0, 32'h6004, 32'h6000, 1'b0, CAUSE_INT);
    addRow("range handler", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT0, 32'h0, 1'b1, CAUSE_ADEL);
    addRow("range next", PLAIN, 32'h0, 32'h0, 1'b0, KTEXT4, KTEXT0, 1'b1, CAUSE_ADEL);
endtask

// ==== bench/frontEndTb.sv ====
// Testbench for the MIPS instruction-fetch front end.
// Plays the instruction memory and the register file, applies the vector
// table row by row with random memory wait states, and checks fetch PC,
// decode PC and word, busy and exception status around every accepted fetch.

`include "frontEnd_defs.svh"

module frontEndTb;
    import frontEndPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 3;
    localparam logic [31:0] SEED = 32'hb8b1_856d;

    // Cause codes as seen on the cause port
    localparam logic [4:0] CAUSE_INT = 5'd0;
    localparam logic [4:0] CAUSE_ADEL = 5'd4;

    // Instruction words and addresses used by the table
    localparam logic [31:0] PLAIN = 32'h2421_0001;
    localparam logic [31:0] ERET = 32'h4200_0018;
    localparam logic [31:0] KTEXT0 = `KTEXT_START;
    localparam logic [31:0] KTEXT4 = `KTEXT_START + 32'd4;
    localparam logic [31:0] KTEXT8 = `KTEXT_START + 32'd8;

    logic        clk;
    logic        reset;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic        instrReady;
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic        interruptRequest;
    logic [31:0] fetchPc;
    logic [31:0] decodePc;
    logic [31:0] decodeCode;
    excCode      cause;
    logic        exceptionLevel;
    logic        busy;

    // Vector table, one entry per accepted fetch
    string       names[$];
    logic [31:0] codes[$];
    logic [31:0] rsList[$];
    logic [31:0] rtList[$];
    logic        irqList[$];
    logic [31:0] pcList[$];
    logic [31:0] decodePcList[$];
    logic        levelList[$];
    logic [4:0]  causeList[$];

    frontEnd dut_i (
        .clk              (clk),
        .reset            (reset),
        .instrAddr        (instrAddr),
        .instrData        (instrData),
        .instrReady       (instrReady),
        .rsValue          (rsValue),
        .rtValue          (rtValue),
        .interruptRequest (interruptRequest),
        .fetchPc          (fetchPc),
        .decodePc         (decodePc),
        .decodeCode       (decodeCode),
        .cause            (cause),
        .exceptionLevel   (exceptionLevel),
        .busy             (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic addRow(input string name, input logic [31:0] code,
                          input logic [31:0] rs, input logic [31:0] rt,
                          input logic irq, input logic [31:0] pc,
                          input logic [31:0] decPc, input logic level,
                          input logic [4:0] excCause);
        names.push_back(name);
        codes.push_back(code);
        rsList.push_back(rs);
        rtList.push_back(rt);
        irqList.push_back(irq);
        pcList.push_back(pc);
        decodePcList.push_back(decPc);
        levelList.push_back(level);
        causeList.push_back(excCause);
    endtask

    `include "frontEndVectors.svh"

    task automatic expectEqual(input string testName, input string signal,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s %s: expected %h, actual %h",
                     testName, signal, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Word expected in decode before the fetch of a row
    function automatic logic [31:0] expectedDecodeCode(input int row);
        logic [31:0] lastPc;
        // Bubble after reset or a flush
        if ((row == 0) || (decodePcList[row] == 32'd0)) begin
            return 32'd0;
        end
        lastPc = pcList[row - 1];
        // A faulting fetch reaches decode as a NOP
        if ((lastPc[1:0] != 2'b00) || (lastPc < `IM_ADDR_START) ||
            (lastPc >= `IM_ADDR_END)) begin
            return 32'd0;
        end
        return codes[row - 1];
    endfunction

    // Everything here is stable at the falling edge
    task automatic checkFetch(input int row, input logic stalled);
        expectEqual(names[row], "fetchPc", pcList[row], fetchPc);
        expectEqual(names[row], "instrAddr", pcList[row], instrAddr);
        expectEqual(names[row], "decodePc", decodePcList[row], decodePc);
        expectEqual(names[row], "decodeCode", expectedDecodeCode(row), decodeCode);
        expectEqual(names[row], "busy", 32'(stalled), 32'(busy));
        expectEqual(names[row], "exceptionLevel", 32'(levelList[row]), 32'(exceptionLevel));
        expectEqual(names[row], "cause", 32'(causeList[row]), 32'(cause));
    endtask

    initial begin
        int waits;
        void'($urandom(SEED));
        clk = 1'b0;
        reset = 1'b1;
        instrData = 32'd0;
        instrReady = 1'b0;
        rsValue = 32'd0;
        rtValue = 32'd0;
        interruptRequest = 1'b0;
        loadVectors();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int row = 0; row < names.size(); row++) begin
            // Memory wait states ahead of this fetch
            waits = int'($urandom % 4);
            repeat (waits) begin
                instrReady <= 1'b0;
                @(negedge clk);
                checkFetch(row, 1'b1);
                @(posedge clk);
            end
            instrReady <= 1'b1;
            instrData <= codes[row];
            @(negedge clk);
            checkFetch(row, 1'b0);
            @(posedge clk);
            // Register values for the instruction now in decode
            rsValue <= rsList[row];
            rtValue <= rtList[row];
            interruptRequest <= irqList[row];
        end
        $display("PASS: all tests");
        $finish;
    end

    // Each row needs at most four cycles and five leave room for reset
    initial begin
        #1;
        repeat (names.size() * 5) @(posedge clk);
        $display("Timeout: fetch stalled and the vector table did not finish");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

// ==== frontEnd.f ====
+incdir+hw
+incdir+bench
hw/frontEndPkg.sv
hw/pipeReg.sv
hw/programCounter.sv
hw/fetchStage.sv
hw/branchDecode.sv
hw/exceptionControl.sv
hw/frontEnd.sv
bench/frontEndTb.sv

// ==== hw/branchDecode.sv ====
// Control-transfer decoder for the instruction in decode.
// Classifies branches, jumps and ERET, resolves the BEQ/BNE compare on
// register values from the register file, and splits out jump fields.
// Purely combinational.

module branchDecode (
    input  logic [31:0]           code,
    input  logic [31:0]           rsValue,
    input  logic [31:0]           rtValue,
    output frontEndPkg::instrKind kind,
    output frontEndPkg::instrFunc func,
    output logic                  compareTrue,
    output logic [15:0]           imm16,
    output logic [25:0]           jumpIndex,
    output logic [31:0]           jumpReg
);
    import frontEndPkg::*;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_COP0    = 6'h10;

    // Function field values
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ERET = 6'h18;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       coBit;

    assign opcode = code[31:26];
    assign funct = code[5:0];
    // CO bit separates COP0 operations from MFC0/MTC0
    assign coBit = code[25];

    always_comb begin
        kind = KIND_OTHER;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    kind = KIND_JR;
                end else if (funct == FN_JALR) begin
                    kind = KIND_JALR;
                end
            end
            OP_J:    kind = KIND_J;
            OP_JAL:  kind = KIND_JAL;
            OP_BEQ:  kind = KIND_BEQ;
            OP_BNE:  kind = KIND_BNE;
            OP_COP0: begin
                if (coBit && (funct == FN_ERET)) begin
                    kind = KIND_ERET;
                end
            end
            default: kind = KIND_OTHER;
        endcase
    end

    always_comb begin
        case (kind)
            KIND_BEQ, KIND_BNE: func = FUNC_BRANCH;
            KIND_J, KIND_JAL, KIND_JR, KIND_JALR: func = FUNC_JUMP;
            default: func = FUNC_PLAIN;
        endcase
    end

    // Compare only means something for the two branch kinds
    always_comb begin
        case (kind)
            KIND_BEQ: compareTrue = (rsValue == rtValue);
            KIND_BNE: compareTrue = (rsValue != rtValue);
            default:  compareTrue = 1'b0;
        endcase
    end

    assign imm16 = code[15:0];
    assign jumpIndex = code[25:0];
    assign jumpReg = rsValue;

endmodule

// ==== hw/exceptionControl.sv ====
// Minimal CP0 for the front end: exception level, EPC and cause.
// Raises entry on a fetch address error or an external interrupt and
// ERET on return, and flushes decode with either command.
// State moves only on accepted fetch edges.

module exceptionControl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  advance,
    input  frontEndPkg::instrKind kind,
    input  logic [31:0]           decodePc,
    input  logic                  decodeDelaySlot,
    input  frontEndPkg::excCode   decodeExc,
    input  logic                  interruptRequest,
    output frontEndPkg::excCtrl   command,
    output logic [29:0]           epc,
    output logic                  flush,
    output frontEndPkg::excCode   cause,
    output logic                  exceptionLevel
);
    import frontEndPkg::*;

    logic        addrError;
    logic        entry;
    decodeStatus decodeNow;
    decodeStatus savedStatus;
    logic [31:0] restartPc;

    assign addrError = (decodeExc == EXC_ADEL);
    // Exceptions are masked while already in the handler
    assign entry = !exceptionLevel && (addrError || interruptRequest);

    always_comb begin
        if (entry) begin
            command = ECTRL_ENTRY;
        end else if (exceptionLevel && (kind == KIND_ERET)) begin
            command = ECTRL_ERET;
        end else begin
            command = ECTRL_NONE;
        end
    end

    assign flush = (command != ECTRL_NONE);

    assign decodeNow.pc = decodePc;
    assign decodeNow.delaySlot = decodeDelaySlot;
    assign decodeNow.exc = decodeExc;

    // Snapshot of the instruction taken out of decode at entry
    pipeReg #(
        .payloadType (decodeStatus)
    ) statusReg_i (
        .clk   (clk),
        .reset (reset),
        .hold  (!(advance && entry)),
        .clear (1'b0),
        .d     (decodeNow),
        .q     (savedStatus)
    );

    // Restart at the branch when the victim sat in a delay slot
    assign restartPc = savedStatus.delaySlot ? (savedStatus.pc - 32'd4) : savedStatus.pc;
    assign epc = restartPc[31:2];

    // Address error outranks the interrupt
    assign cause = (savedStatus.exc == EXC_ADEL) ? EXC_ADEL : EXC_INT;

    always_ff @(posedge clk) begin
        if (reset) begin
            exceptionLevel <= 1'b0;
        end else if (advance) begin
            if (command == ECTRL_ENTRY) begin
                exceptionLevel <= 1'b1;
            end else if (command == ECTRL_ERET) begin
                exceptionLevel <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/fetchStage.sv ====
// Fetch stage of the pipeline.
// Drives the instruction-memory address from the PC, stalls while the
// memory is not ready, and registers the fetch bundle for decode.
// A flush from exception control turns the next decode entry into a bubble.

module fetchStage (
    input  logic                  clk,
    input  logic                  reset,
    output logic [31:0]           instrAddr,
    input  logic [31:0]           instrData,
    input  logic                  instrReady,
    input  frontEndPkg::instrKind kind,
    input  frontEndPkg::instrFunc func,
    input  logic                  compareTrue,
    input  logic [15:0]           imm16,
    input  logic [25:0]           jumpIndex,
    input  logic [31:0]           jumpReg,
    input  frontEndPkg::excCtrl   command,
    input  logic [29:0]           epc,
    input  logic                  flush,
    output logic [31:0]           decodeCode,
    output logic [31:0]           decodePc,
    output logic                  decodeDelaySlot,
    output frontEndPkg::excCode   decodeExc,
    output logic [31:0]           fetchPc,
    output logic                  busy
);
    import frontEndPkg::*;

    logic       fetchDelaySlot;
    excCode     fetchExc;
    fetchBundle fetchData;
    fetchBundle decodeData;

    programCounter counter_i (
        .clk         (clk),
        .reset       (reset),
        .enable      (instrReady),
        .kind        (kind),
        .func        (func),
        .compareTrue (compareTrue),
        .imm16       (imm16),
        .jumpIndex   (jumpIndex),
        .jumpReg     (jumpReg),
        .command     (command),
        .epc         (epc),
        .pc          (fetchPc),
        .delaySlot   (fetchDelaySlot),
        .fetchExc    (fetchExc)
    );

    assign instrAddr = fetchPc;
    assign busy = !instrReady;

    // A faulting fetch carries a NOP so decode never acts on stray data
    assign fetchData.code = (fetchExc == EXC_ADEL) ? 32'd0 : instrData;
    assign fetchData.pc = fetchPc;
    assign fetchData.delaySlot = fetchDelaySlot;
    assign fetchData.exc = fetchExc;

    pipeReg #(
        .payloadType (fetchBundle)
    ) fetchReg_i (
        .clk   (clk),
        .reset (reset),
        .hold  (!instrReady),
        .clear (flush),
        .d     (fetchData),
        .q     (decodeData)
    );

    assign decodeCode = decodeData.code;
    assign decodePc = decodeData.pc;
    assign decodeDelaySlot = decodeData.delaySlot;
    assign decodeExc = decodeData.exc;

endmodule

// ==== hw/frontEnd.sv ====
// Top level of the instruction-fetch front end.
// Connects fetch, control-transfer decode and exception control.
// Instruction memory and register-file values come from outside;
// the interrupt request is a plain level.

module frontEnd (
    input  logic                clk,
    input  logic                reset,
    output logic [31:0]         instrAddr,
    input  logic [31:0]         instrData,
    input  logic                instrReady,
    input  logic [31:0]         rsValue,
    input  logic [31:0]         rtValue,
    input  logic                interruptRequest,
    output logic [31:0]         fetchPc,
    output logic [31:0]         decodePc,
    output logic [31:0]         decodeCode,
    output frontEndPkg::excCode cause,
    output logic                exceptionLevel,
    output logic                busy
);
    import frontEndPkg::*;

    instrKind    kind;
    instrFunc    func;
    logic        compareTrue;
    logic [15:0] imm16;
    logic [25:0] jumpIndex;
    logic [31:0] jumpReg;
    excCtrl      excCommand;
    logic [29:0] epc;
    logic        flush;
    logic        decodeDelaySlot;
    excCode      decodeExc;

    fetchStage fetch_i (
        .clk             (clk),
        .reset           (reset),
        .instrAddr       (instrAddr),
        .instrData       (instrData),
        .instrReady      (instrReady),
        .kind            (kind),
        .func            (func),
        .compareTrue     (compareTrue),
        .imm16           (imm16),
        .jumpIndex       (jumpIndex),
        .jumpReg         (jumpReg),
        .command         (excCommand),
        .epc             (epc),
        .flush           (flush),
        .decodeCode      (decodeCode),
        .decodePc        (decodePc),
        .decodeDelaySlot (decodeDelaySlot),
        .decodeExc       (decodeExc),
        .fetchPc         (fetchPc),
        .busy            (busy)
    );

    branchDecode decode_i (
        .code        (decodeCode),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .kind        (kind),
        .func        (func),
        .compareTrue (compareTrue),
        .imm16       (imm16),
        .jumpIndex   (jumpIndex),
        .jumpReg     (jumpReg)
    );

    // Exception state advances with fetch
    exceptionControl exc_i (
        .clk              (clk),
        .reset            (reset),
        .advance          (instrReady),
        .kind             (kind),
        .decodePc         (decodePc),
        .decodeDelaySlot  (decodeDelaySlot),
        .decodeExc        (decodeExc),
        .interruptRequest (interruptRequest),
        .command          (excCommand),
        .epc              (epc),
        .flush            (flush),
        .cause            (cause),
        .exceptionLevel   (exceptionLevel)
    );

endmodule

// ==== hw/frontEndPkg.sv ====
// Shared types for the MIPS instruction-fetch front end.
// Decode kinds, function classes, exception commands and cause codes,
// plus the payload structs carried by the stage registers.
// Import with a wildcard inside any module body that needs them.

package frontEndPkg;

    // Control-transfer instructions seen by decode
    typedef enum logic [3:0] {
        KIND_OTHER = 4'd0,
        KIND_BEQ   = 4'd1,
        KIND_BNE   = 4'd2,
        KIND_J     = 4'd3,
        KIND_JAL   = 4'd4,
        KIND_JR    = 4'd5,
        KIND_JALR  = 4'd6,
        KIND_ERET  = 4'd7
    } instrKind;

    typedef enum logic [1:0] {
        FUNC_PLAIN  = 2'd0,
        FUNC_BRANCH = 2'd1,
        FUNC_JUMP   = 2'd2
    } instrFunc;

    // Command from exception control to the PC
    typedef enum logic [1:0] {
        ECTRL_NONE  = 2'd0,
        ECTRL_ENTRY = 2'd1,
        ECTRL_ERET  = 2'd2
    } excCtrl;

    // MIPS ExcCode values; NONE sits outside the architectural codes
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_NONE = 5'd31
    } excCode;

    typedef struct packed {
        logic [31:0] code;
        logic [31:0] pc;
        logic        delaySlot;
        excCode      exc;
    } fetchBundle;

    typedef struct packed {
        logic [31:0] pc;
        logic        delaySlot;
        excCode      exc;
    } decodeStatus;

endpackage

// ==== hw/frontEnd_defs.svh ====
// Address map of the instruction-fetch front end.
// Boot PC, exception vector and the legal instruction-memory window.
// Include in any file that needs a fixed address.

`ifndef FRONT_END_DEFS_SVH
`define FRONT_END_DEFS_SVH

// First instruction after reset
`define PC_BOOT       32'h0000_3000

// Exception and interrupt vector
`define KTEXT_START   32'h0000_4180

// Fetch window with an exclusive end address
`define IM_ADDR_START 32'h0000_3000
`define IM_ADDR_END   32'h0000_5000

`endif

// ==== hw/pipeReg.sv ====
// Generic pipeline stage register.
// Loads d every cycle unless held; clear empties it to a zero payload.
// Hold gates both load and clear, and clear wins over load.

module pipeReg #(
    parameter type payloadType = logic
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       hold,
    input  logic       clear,
    input  payloadType d,
    output payloadType q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (!hold) begin
            if (clear) begin
                // Bubble
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

// ==== hw/programCounter.sv ====
// Program counter with next-PC selection for the fetch stage.
// Decode supplies branch and jump fields, exception control supplies
// entry and return commands. Fetch faults are flagged as ADEL.
// Instantiated once inside fetchStage.

`include "frontEnd_defs.svh"

module programCounter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  frontEndPkg::instrKind kind,
    input  frontEndPkg::instrFunc func,
    input  logic                 compareTrue,
    input  logic [15:0]          imm16,
    input  logic [25:0]          jumpIndex,
    input  logic [31:0]          jumpReg,
    input  frontEndPkg::excCtrl  command,
    input  logic [29:0]          epc,
    output logic [31:0]          pc,
    output logic                 delaySlot,
    output frontEndPkg::excCode  fetchExc
);
    import frontEndPkg::*;

    logic [31:0] branchOffset;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic        inRange;
    logic        misaligned;

    // Word-scaled, sign-extended branch displacement
    assign branchOffset = {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget = {pc[31:28], jumpIndex, 2'b00};

    // Anything in decode that transfers control makes this fetch a delay slot
    assign delaySlot = (func == FUNC_BRANCH) || (func == FUNC_JUMP);

    // Entry wins over return, then register jump, immediate jump and branch
    always_comb begin
        if (command == ECTRL_ENTRY) begin
            nextPc = `KTEXT_START;
        end else if (command == ECTRL_ERET) begin
            nextPc = {epc, 2'b00};
        end else if ((kind == KIND_JR) || (kind == KIND_JALR)) begin
            nextPc = jumpReg;
        end else if ((kind == KIND_J) || (kind == KIND_JAL)) begin
            nextPc = jumpTarget;
        end else if ((func == FUNC_BRANCH) && compareTrue) begin
            // pc here is already the delay slot
            nextPc = pc + branchOffset;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `PC_BOOT;
        end else if (enable) begin
            pc <= nextPc;
        end
    end

    // Fetch address check
    assign inRange = (pc >= `IM_ADDR_START) && (pc < `IM_ADDR_END);
    assign misaligned = (pc[1:0] != 2'b00);

    always_comb begin
        if (!inRange || misaligned) begin
            fetchExc = EXC_ADEL;
        end else begin
            fetchExc = EXC_NONE;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the front-end testbench with Verilator and run it.
# The exit status is the simulator's own, so a failing run fails the script.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module frontEndTb -f frontEnd.f \
    --Mdir obj_dir -o frontEndSim

./obj_dir/frontEndSim
